// ==== fu_pkg.sv ====
package fu_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int XLEN    = 32;
    localparam int COUNT_W = 3;
    localparam int SHAMT_W = 5;

    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [31:0]        inst_t;
    typedef logic [5:0]         tag_t;     // Physical register tag
    typedef logic [4:0]         rob_idx_t;
    typedef logic [COUNT_W-1:0] count_t;

    // Extra wait cycles after the accepting edge
    localparam int ALU_LATENCY  = 1;
    localparam int MULT_LATENCY = 4;
    localparam int BR_LATENCY   = 1;

    // Seen on an output only when a selector or function code is illegal
    localparam xlen_t BAD_OPA_VALUE  = 32'hdeadfbac;
    localparam xlen_t BAD_OPB_VALUE  = 32'hfacefeed;
    localparam xlen_t BAD_FUNC_VALUE = 32'hfacebeec;

    ////////////////////
    // Encodings
    ////////////////////
    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_NPC,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT, ALU_SLTU,
        ALU_OR, ALU_XOR, ALU_SRL, ALU_SLL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    typedef enum logic [1:0] {
        FU_IDLE,
        FU_BUSY,
        FU_DONE
    } fu_state_e;

endpackage

// ==== operand_mux.sv ====
`timescale 1ns/1ps

module operand_mux
    import fu_pkg::*;
(
    input  inst_t    inst_i,
    input  xlen_t    pc_i,
    input  xlen_t    npc_i,
    input  xlen_t    rs1_value_i,
    input  xlen_t    rs2_value_i,
    input  opa_sel_e opa_sel_i,
    input  opb_sel_e opb_sel_i,
    output xlen_t    opa_o,
    output xlen_t    opb_o
);
    xlen_t i_imm, s_imm, b_imm, u_imm, j_imm;

    // Immediates, sign bit is always inst[31]
    assign i_imm = {{20{inst_i[31]}}, inst_i[31:20]};
    assign s_imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign b_imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign u_imm = {inst_i[31:12], 12'b0};
    assign j_imm = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        opa_o = BAD_OPA_VALUE;
        case (opa_sel_i)
            OPA_IS_RS1:  opa_o = rs1_value_i;
            OPA_IS_NPC:  opa_o = npc_i;
            OPA_IS_PC:   opa_o = pc_i;
            OPA_IS_ZERO: opa_o = '0;
            default:     opa_o = BAD_OPA_VALUE;
        endcase
    end

    always_comb begin
        opb_o = BAD_OPB_VALUE; // Codes 6 and 7 unused
        case (opb_sel_i)
            OPB_IS_RS2:   opb_o = rs2_value_i;
            OPB_IS_I_IMM: opb_o = i_imm;
            OPB_IS_S_IMM: opb_o = s_imm;
            OPB_IS_B_IMM: opb_o = b_imm;
            OPB_IS_U_IMM: opb_o = u_imm;
            OPB_IS_J_IMM: opb_o = j_imm;
            default:      opb_o = BAD_OPB_VALUE;
        endcase
    end

    // Whatever issued this instruction must have sent a defined B select
    always_comb begin
        if (!$isunknown(opb_sel_i)) begin
            assert (opb_sel_i <= OPB_IS_J_IMM)
                else $error("operand_mux: illegal opb_sel %0d", opb_sel_i);
        end
    end

endmodule

// ==== int_alu.sv ====
`timescale 1ns/1ps

module int_alu
    import fu_pkg::*;
(
    input  xlen_t     opa_i,
    input  xlen_t     opb_i,
    input  alu_func_e func_i,
    output xlen_t     result_o
);
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = opb_i[SHAMT_W-1:0];
    assign lt_signed   = $signed(opa_i) < $signed(opb_i);
    assign lt_unsigned = opa_i < opb_i;

    always_comb begin
        case (func_i)
            ALU_ADD:  result_o = opa_i + opb_i;
            ALU_SUB:  result_o = opa_i - opb_i;
            ALU_AND:  result_o = opa_i & opb_i;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_OR:   result_o = opa_i | opb_i;
            ALU_XOR:  result_o = opa_i ^ opb_i;
            ALU_SRL:  result_o = opa_i >> shamt;
            ALU_SLL:  result_o = opa_i << shamt;
            ALU_SRA:  result_o = xlen_t'($signed(opa_i) >>> shamt);
            default:  result_o = BAD_FUNC_VALUE; // Multiply codes land here
        endcase
    end

endmodule

// ==== fu_sequencer.sv ====
`timescale 1ns/1ps

module fu_sequencer
    import fu_pkg::*;
#(
    parameter int LATENCY = 1
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic start_i,
    input  logic ack_i,
    output logic ready_o,
    output logic valid_o,
    output logic accept_o
);
    fu_state_e state_q;
    count_t    count_q;

    // Ack beats a start arriving on the same edge
    assign accept_o = ready_o && start_i && !ack_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= FU_IDLE;
            count_q <= '0;
            ready_o <= 1'b1;
            valid_o <= 1'b0;
        end else begin
            case (state_q)
                FU_IDLE: if (accept_o) begin
                    state_q <= FU_BUSY;
                    count_q <= '0;
                    ready_o <= 1'b0;
                end
                FU_BUSY: if (count_q == count_t'(LATENCY)) begin
                    state_q <= FU_DONE;
                    valid_o <= 1'b1;
                end else begin
                    count_q <= count_q + 1'b1;
                end
                FU_DONE: if (ack_i) begin
                    state_q <= FU_IDLE; // Broadcast taken, free again
                    ready_o <= 1'b1;
                    valid_o <= 1'b0;
                end
                default: state_q <= FU_IDLE;
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    assert property (@(posedge clk_i) disable iff (reset_i) !(ready_o && valid_o));
    assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(valid_o) |-> ($past(ack_i) || $past(reset_i)));

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
    import fu_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      start_i,
    input  logic      ack_i,
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  xlen_t     npc_i,
    input  xlen_t     rs1_value_i,
    input  xlen_t     rs2_value_i,
    input  opa_sel_e  opa_sel_i,
    input  opb_sel_e  opb_sel_i,
    input  alu_func_e alu_func_i,
    input  tag_t      tag_i,
    input  rob_idx_t  rob_idx_i,
    output logic      ready_o,
    output logic      valid_o,
    output xlen_t     result_o,
    output tag_t      tag_o,
    output rob_idx_t  rob_idx_o
);
    logic      accept;
    inst_t     inst_q;
    xlen_t     pc_q, npc_q, rs1_q, rs2_q;
    opa_sel_e  opa_sel_q;
    opb_sel_e  opb_sel_q;
    alu_func_e func_q;
    tag_t      tag_q;
    rob_idx_t  rob_idx_q;
    xlen_t     opa, opb, alu_out;

    fu_sequencer #(.LATENCY(ALU_LATENCY)) u_seq (
        .clk_i(clk_i), .reset_i(reset_i), .start_i(start_i), .ack_i(ack_i),
        .ready_o(ready_o), .valid_o(valid_o), .accept_o(accept)
    );

    always_ff @(posedge clk_i) begin
        if (accept) begin // Snapshot of the issue bus
            inst_q    <= inst_i;
            pc_q      <= pc_i;
            npc_q     <= npc_i;
            rs1_q     <= rs1_value_i;
            rs2_q     <= rs2_value_i;
            opa_sel_q <= opa_sel_i;
            opb_sel_q <= opb_sel_i;
            func_q    <= alu_func_i;
            tag_q     <= tag_i;
            rob_idx_q <= rob_idx_i;
        end
    end

    operand_mux u_opmux (
        .inst_i(inst_q), .pc_i(pc_q), .npc_i(npc_q),
        .rs1_value_i(rs1_q), .rs2_value_i(rs2_q),
        .opa_sel_i(opa_sel_q), .opb_sel_i(opb_sel_q),
        .opa_o(opa), .opb_o(opb)
    );

    int_alu u_alu (.opa_i(opa), .opb_i(opb), .func_i(func_q), .result_o(alu_out));

    // Last load while busy is the edge valid rises, then frozen
    always_ff @(posedge clk_i) begin
        if (!ready_o && !valid_o) begin
            result_o  <= alu_out;
            tag_o     <= tag_q;
            rob_idx_o <= rob_idx_q;
        end
    end

endmodule

// ==== mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit
    import fu_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      start_i,
    input  logic      ack_i,
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  xlen_t     npc_i,
    input  xlen_t     rs1_value_i,
    input  xlen_t     rs2_value_i,
    input  opa_sel_e  opa_sel_i,
    input  opb_sel_e  opb_sel_i,
    input  alu_func_e alu_func_i,
    input  tag_t      tag_i,
    input  rob_idx_t  rob_idx_i,
    output logic      ready_o,
    output logic      valid_o,
    output xlen_t     result_o,
    output tag_t      tag_o,
    output rob_idx_t  rob_idx_o
);
    logic                   accept;
    inst_t                  inst_q;
    xlen_t                  pc_q, npc_q, rs1_q, rs2_q;
    opa_sel_e               opa_sel_q;
    opb_sel_e               opb_sel_q;
    alu_func_e              func_q;
    tag_t                   tag_q;
    rob_idx_t               rob_idx_q;
    xlen_t                  opa, opb, mul_out;
    logic [2*XLEN-1:0]      prod_ss, prod_uu, prod_su;

    fu_sequencer #(.LATENCY(MULT_LATENCY)) u_seq (
        .clk_i(clk_i), .reset_i(reset_i), .start_i(start_i), .ack_i(ack_i),
        .ready_o(ready_o), .valid_o(valid_o), .accept_o(accept)
    );

    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q    <= inst_i;
            pc_q      <= pc_i;
            npc_q     <= npc_i;
            rs1_q     <= rs1_value_i;
            rs2_q     <= rs2_value_i;
            opa_sel_q <= opa_sel_i;
            opb_sel_q <= opb_sel_i;
            func_q    <= alu_func_i;
            tag_q     <= tag_i;
            rob_idx_q <= rob_idx_i;
        end
    end

    operand_mux u_opmux (
        .inst_i(inst_q), .pc_i(pc_q), .npc_i(npc_q),
        .rs1_value_i(rs1_q), .rs2_value_i(rs2_q),
        .opa_sel_i(opa_sel_q), .opb_sel_i(opb_sel_q),
        .opa_o(opa), .opb_o(opb)
    );

    ////////////////////
    // Products
    ////////////////////
    assign prod_ss = $signed({{XLEN{opa[XLEN-1]}}, opa}) * $signed({{XLEN{opb[XLEN-1]}}, opb});
    assign prod_uu = {{XLEN{1'b0}}, opa} * {{XLEN{1'b0}}, opb};
    assign prod_su = $signed({{XLEN{opa[XLEN-1]}}, opa}) * $signed({{XLEN{1'b0}}, opb});

    always_comb begin
        case (func_q)
            ALU_MUL:    mul_out = prod_ss[XLEN-1:0]; // Low word same for any sign
            ALU_MULH:   mul_out = prod_ss[2*XLEN-1:XLEN];
            ALU_MULHSU: mul_out = prod_su[2*XLEN-1:XLEN];
            ALU_MULHU:  mul_out = prod_uu[2*XLEN-1:XLEN];
            default:    mul_out = BAD_FUNC_VALUE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!ready_o && !valid_o) begin
            result_o  <= mul_out;
            tag_o     <= tag_q;
            rob_idx_o <= rob_idx_q;
        end
    end

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit
    import fu_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      start_i,
    input  logic      ack_i,
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  xlen_t     npc_i,
    input  xlen_t     rs1_value_i,
    input  xlen_t     rs2_value_i,
    input  opa_sel_e  opa_sel_i,
    input  opb_sel_e  opb_sel_i,
    input  alu_func_e alu_func_i,
    input  logic      cond_branch_i,
    input  logic      uncond_branch_i,
    input  tag_t      tag_i,
    input  rob_idx_t  rob_idx_i,
    output logic      ready_o,
    output logic      valid_o,
    output logic      taken_o,
    output xlen_t     target_o,
    output tag_t      tag_o,
    output rob_idx_t  rob_idx_o
);
    logic      accept;
    inst_t     inst_q;
    xlen_t     pc_q, npc_q, rs1_q, rs2_q;
    opa_sel_e  opa_sel_q;
    opb_sel_e  opb_sel_q;
    alu_func_e func_q;
    logic      cond_q, uncond_q;
    tag_t      tag_q;
    rob_idx_t  rob_idx_q;
    xlen_t     opa, opb, target;
    logic      cond_true;
    logic      take;

    fu_sequencer #(.LATENCY(BR_LATENCY)) u_seq (
        .clk_i(clk_i), .reset_i(reset_i), .start_i(start_i), .ack_i(ack_i),
        .ready_o(ready_o), .valid_o(valid_o), .accept_o(accept)
    );

    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q    <= inst_i;
            pc_q      <= pc_i;
            npc_q     <= npc_i;
            rs1_q     <= rs1_value_i;
            rs2_q     <= rs2_value_i;
            opa_sel_q <= opa_sel_i;
            opb_sel_q <= opb_sel_i;
            func_q    <= alu_func_i;
            cond_q    <= cond_branch_i;
            uncond_q  <= uncond_branch_i;
            tag_q     <= tag_i;
            rob_idx_q <= rob_idx_i;
        end
    end

    operand_mux u_opmux (
        .inst_i(inst_q), .pc_i(pc_q), .npc_i(npc_q),
        .rs1_value_i(rs1_q), .rs2_value_i(rs2_q),
        .opa_sel_i(opa_sel_q), .opb_sel_i(opb_sel_q),
        .opa_o(opa), .opb_o(opb)
    );

    // Target address, normally PC plus B or J immediate
    int_alu u_alu (.opa_i(opa), .opb_i(opb), .func_i(func_q), .result_o(target));

    ////////////////////
    // Condition
    ////////////////////
    always_comb begin
        case (inst_q[14:12]) // funct3
            3'b000:  cond_true = rs1_q == rs2_q;                   // BEQ
            3'b001:  cond_true = rs1_q != rs2_q;                   // BNE
            3'b100:  cond_true = $signed(rs1_q) < $signed(rs2_q);  // BLT
            3'b101:  cond_true = $signed(rs1_q) >= $signed(rs2_q); // BGE
            3'b110:  cond_true = rs1_q < rs2_q;                    // BLTU
            3'b111:  cond_true = rs1_q >= rs2_q;                   // BGEU
            default: cond_true = 1'b0;
        endcase
    end

    assign take = uncond_q || (cond_q && cond_true);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            taken_o <= 1'b0;
        end else if (!ready_o && !valid_o) begin
            taken_o <= take;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!ready_o && !valid_o) begin
            target_o  <= target;
            tag_o     <= tag_q;
            rob_idx_o <= rob_idx_q;
        end
    end

endmodule

// ==== fu_top.sv ====
`timescale 1ns/1ps

module fu_top
    import fu_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    // Shared issue bus
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  xlen_t     npc_i,
    input  xlen_t     rs1_value_i,
    input  xlen_t     rs2_value_i,
    input  opa_sel_e  opa_sel_i,
    input  opb_sel_e  opb_sel_i,
    input  alu_func_e alu_func_i,
    input  logic      cond_branch_i,
    input  logic      uncond_branch_i,
    input  tag_t      tag_i,
    input  rob_idx_t  rob_idx_i,
    // Per-unit strobes
    input  logic      alu_start_i,
    input  logic      alu_ack_i,
    input  logic      mult_start_i,
    input  logic      mult_ack_i,
    input  logic      br_start_i,
    input  logic      br_ack_i,
    // ALU unit
    output logic      alu_ready_o,
    output logic      alu_valid_o,
    output xlen_t     alu_result_o,
    output tag_t      alu_tag_o,
    output rob_idx_t  alu_rob_idx_o,
    // Multiply unit
    output logic      mult_ready_o,
    output logic      mult_valid_o,
    output xlen_t     mult_result_o,
    output tag_t      mult_tag_o,
    output rob_idx_t  mult_rob_idx_o,
    // Branch unit
    output logic      br_ready_o,
    output logic      br_valid_o,
    output logic      br_taken_o,
    output xlen_t     br_target_o,
    output tag_t      br_tag_o,
    output rob_idx_t  br_rob_idx_o
);

    alu_unit u_alu (
        .clk_i(clk_i), .reset_i(reset_i), .start_i(alu_start_i), .ack_i(alu_ack_i),
        .inst_i(inst_i), .pc_i(pc_i), .npc_i(npc_i),
        .rs1_value_i(rs1_value_i), .rs2_value_i(rs2_value_i),
        .opa_sel_i(opa_sel_i), .opb_sel_i(opb_sel_i), .alu_func_i(alu_func_i),
        .tag_i(tag_i), .rob_idx_i(rob_idx_i),
        .ready_o(alu_ready_o), .valid_o(alu_valid_o), .result_o(alu_result_o),
        .tag_o(alu_tag_o), .rob_idx_o(alu_rob_idx_o)
    );

    mult_unit u_mult (
        .clk_i(clk_i), .reset_i(reset_i), .start_i(mult_start_i), .ack_i(mult_ack_i),
        .inst_i(inst_i), .pc_i(pc_i), .npc_i(npc_i),
        .rs1_value_i(rs1_value_i), .rs2_value_i(rs2_value_i),
        .opa_sel_i(opa_sel_i), .opb_sel_i(opb_sel_i), .alu_func_i(alu_func_i),
        .tag_i(tag_i), .rob_idx_i(rob_idx_i),
        .ready_o(mult_ready_o), .valid_o(mult_valid_o), .result_o(mult_result_o),
        .tag_o(mult_tag_o), .rob_idx_o(mult_rob_idx_o)
    );

    branch_unit u_br (
        .clk_i(clk_i), .reset_i(reset_i), .start_i(br_start_i), .ack_i(br_ack_i),
        .inst_i(inst_i), .pc_i(pc_i), .npc_i(npc_i),
        .rs1_value_i(rs1_value_i), .rs2_value_i(rs2_value_i),
        .opa_sel_i(opa_sel_i), .opb_sel_i(opb_sel_i), .alu_func_i(alu_func_i),
        .cond_branch_i(cond_branch_i), .uncond_branch_i(uncond_branch_i),
        .tag_i(tag_i), .rob_idx_i(rob_idx_i),
        .ready_o(br_ready_o), .valid_o(br_valid_o), .taken_o(br_taken_o),
        .target_o(br_target_o), .tag_o(br_tag_o), .rob_idx_o(br_rob_idx_o)
    );

endmodule

// ==== fu_checker.sv ====
`timescale 1ns/1ps

module fu_checker
    import fu_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  xlen_t     npc_i,
    input  xlen_t     rs1_value_i,
    input  xlen_t     rs2_value_i,
    input  opa_sel_e  opa_sel_i,
    input  opb_sel_e  opb_sel_i,
    input  alu_func_e alu_func_i,
    input  logic      cond_branch_i,
    input  logic      uncond_branch_i,
    input  tag_t      tag_i,
    input  rob_idx_t  rob_idx_i,
    input  logic [2:0] start_i,   // Index 0 ALU, 1 multiply, 2 branch
    input  logic [2:0] ack_i,
    input  logic [2:0] ready_i,
    input  logic [2:0] valid_i,
    input  xlen_t     alu_result_i,
    input  xlen_t     mult_result_i,
    input  xlen_t     br_target_i,
    input  logic      br_taken_i,
    input  tag_t      alu_tag_i,
    input  tag_t      mult_tag_i,
    input  tag_t      br_tag_i,
    input  rob_idx_t  alu_rob_i,
    input  rob_idx_t  mult_rob_i,
    input  rob_idx_t  br_rob_i,
    output int        err_count_o,
    output int        result_count_o
);
    xlen_t    exp_val[3];
    tag_t     exp_tag[3];
    rob_idx_t exp_rob[3];
    logic     exp_taken;
    logic     pending[3];
    logic     seen[3];
    int       cyc[3];
    logic     was_reset;

    //////////////////// Reference model
    function automatic xlen_t select_opa(opa_sel_e sel, xlen_t rs1, xlen_t pc, xlen_t npc);
        case (sel)
            OPA_IS_RS1: return rs1;
            OPA_IS_NPC: return npc;
            OPA_IS_PC:  return pc;
            default:    return '0;
        endcase
    endfunction

    function automatic xlen_t select_opb(opb_sel_e sel, inst_t i, xlen_t rs2);
        case (sel)
            OPB_IS_RS2:   return rs2;
            OPB_IS_I_IMM: return {{20{i[31]}}, i[31:20]};
            OPB_IS_S_IMM: return {{20{i[31]}}, i[31:25], i[11:7]};
            OPB_IS_B_IMM: return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            OPB_IS_U_IMM: return {i[31:12], 12'h000};
            default:      return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0}; // J
        endcase
    endfunction

    // Expected unit result or branch target
    function automatic xlen_t compute_result(int u, alu_func_e f, xlen_t a, xlen_t b);
        logic signed [63:0] sa, sb, ub;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ub = {32'h0, b};
        if (u == 1) begin
            case (f)
                ALU_MUL:    return xlen_t'(sa * sb);
                ALU_MULH:   return xlen_t'((sa * sb) >>> 32);
                ALU_MULHSU: return xlen_t'((sa * ub) >>> 32);
                ALU_MULHU:  return xlen_t'(({32'h0, a} * ub) >> 32);
                default:    return BAD_FUNC_VALUE;
            endcase
        end
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_SLT:  return {31'h0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'h0, a < b};
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SLL:  return a << b[4:0];
            ALU_SRA:  return xlen_t'($signed(a) >>> b[4:0]);
            default:  return BAD_FUNC_VALUE;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, xlen_t a, xlen_t b, logic c, logic u);
        logic t;
        case (f3)
            3'b000:  t = a == b;
            3'b001:  t = a != b;
            3'b100:  t = $signed(a) < $signed(b);
            3'b101:  t = $signed(a) >= $signed(b);
            3'b110:  t = a < b;
            3'b111:  t = a >= b;
            default: t = 1'b0;
        endcase
        return u || (c && t);
    endfunction

    function automatic int latency_of(int u);
        return (u == 0) ? ALU_LATENCY : (u == 1) ? MULT_LATENCY : BR_LATENCY;
    endfunction

    //////////////////// Comparing
    task automatic cmp(string name, logic [31:0] exp, logic [31:0] got);
        if (exp !== got) begin
            $display("mismatch %s expected %h actual %h", name, exp, got);
            err_count_o++;
        end
    endtask

    task automatic compare_unit(int u);
        case (u)
            0: begin
                cmp("alu_result_o", exp_val[0], alu_result_i);
                cmp("alu_tag_o", 32'(exp_tag[0]), 32'(alu_tag_i));
                cmp("alu_rob_idx_o", 32'(exp_rob[0]), 32'(alu_rob_i));
            end
            1: begin
                cmp("mult_result_o", exp_val[1], mult_result_i);
                cmp("mult_tag_o", 32'(exp_tag[1]), 32'(mult_tag_i));
                cmp("mult_rob_idx_o", 32'(exp_rob[1]), 32'(mult_rob_i));
            end
            default: begin
                cmp("br_target_o", exp_val[2], br_target_i);
                cmp("br_taken_o", 32'(exp_taken), 32'(br_taken_i));
                cmp("br_tag_o", 32'(exp_tag[2]), 32'(br_tag_i));
                cmp("br_rob_idx_o", 32'(exp_rob[2]), 32'(br_rob_i));
            end
        endcase
    endtask

    initial begin
        err_count_o    = 0;
        result_count_o = 0;
    end

    // Samples the values from before each edge
    always @(posedge clk_i) begin
        if (was_reset && !reset_i) begin // Outputs left by the last reset edge
            cmp("{br,mult,alu}_ready_o", 32'h7, 32'(ready_i));
            cmp("{br,mult,alu}_valid_o", 32'h0, 32'(valid_i));
            cmp("br_taken_o", 32'h0, 32'(br_taken_i));
        end
        was_reset = reset_i;
        for (int u = 0; u < 3; u++) begin
            if (reset_i) begin
                pending[u] = 1'b0;
                seen[u]    = 1'b0;
            end else if (pending[u]) begin
                cyc[u]++;
                if (ready_i[u]) begin
                    $display("unit %0d shows ready while an instruction is in flight", u);
                    err_count_o++;
                end
                if (valid_i[u]) begin
                    if (!seen[u]) begin
                        result_count_o++;
                        if (cyc[u] != latency_of(u) + 2) begin
                            $display("unit %0d raised valid %0d cycles after start, wanted %0d",
                                     u, cyc[u] - 1, latency_of(u) + 1);
                            err_count_o++;
                        end
                    end
                    seen[u] = 1'b1;
                    compare_unit(u); // Repeated on every held cycle
                    if (ack_i[u]) pending[u] = 1'b0;
                end else if (seen[u]) begin
                    $display("unit %0d dropped valid without an ack", u);
                    err_count_o++;
                    pending[u] = 1'b0;
                end
            end else begin
                if (valid_i[u]) begin
                    $display("unit %0d raised valid with no accepted start", u);
                    err_count_o++;
                end
                if (ready_i[u] && start_i[u] && !ack_i[u]) begin
                    pending[u] = 1'b1;
                    seen[u]    = 1'b0;
                    cyc[u]     = 0;
                    exp_tag[u] = tag_i;
                    exp_rob[u] = rob_idx_i;
                    exp_val[u] = compute_result(u, alu_func_i,
                        select_opa(opa_sel_i, rs1_value_i, pc_i, npc_i),
                        select_opb(opb_sel_i, inst_i, rs2_value_i));
                    if (u == 2) begin
                        exp_taken = branch_taken(inst_i[14:12], rs1_value_i, rs2_value_i,
                                                 cond_branch_i, uncond_branch_i);
                    end
                end
            end
        end
    end

endmodule

// ==== fu_tb.sv ====
`timescale 1ns/1ps

module fu_tb
    import fu_pkg::*;
;
    logic      clk, reset;
    inst_t     inst;
    xlen_t     pc, npc, rs1, rs2;
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    alu_func_e func;
    logic      cond, uncond;
    tag_t      tag;
    rob_idx_t  rob;
    logic [2:0] start, ack, ready, valid;
    xlen_t     alu_result, mult_result, br_target;
    logic      br_taken;
    tag_t      alu_tag, mult_tag, br_tag;
    rob_idx_t  alu_rob, mult_rob, br_rob;
    int        chk_errs, results;
    logic [31:0] lcg_state;
    int        tb_errs, tests_run, tests_failed, errs_before;
    logic      timed_out;

    fu_top dut0 (
        .clk_i(clk), .reset_i(reset), .inst_i(inst), .pc_i(pc), .npc_i(npc),
        .rs1_value_i(rs1), .rs2_value_i(rs2), .opa_sel_i(opa_sel), .opb_sel_i(opb_sel),
        .alu_func_i(func), .cond_branch_i(cond), .uncond_branch_i(uncond),
        .tag_i(tag), .rob_idx_i(rob),
        .alu_start_i(start[0]), .alu_ack_i(ack[0]), .mult_start_i(start[1]),
        .mult_ack_i(ack[1]), .br_start_i(start[2]), .br_ack_i(ack[2]),
        .alu_ready_o(ready[0]), .alu_valid_o(valid[0]), .alu_result_o(alu_result),
        .alu_tag_o(alu_tag), .alu_rob_idx_o(alu_rob),
        .mult_ready_o(ready[1]), .mult_valid_o(valid[1]), .mult_result_o(mult_result),
        .mult_tag_o(mult_tag), .mult_rob_idx_o(mult_rob),
        .br_ready_o(ready[2]), .br_valid_o(valid[2]), .br_taken_o(br_taken),
        .br_target_o(br_target), .br_tag_o(br_tag), .br_rob_idx_o(br_rob)
    );

    fu_checker u_checker (
        .clk_i(clk), .reset_i(reset), .inst_i(inst), .pc_i(pc), .npc_i(npc),
        .rs1_value_i(rs1), .rs2_value_i(rs2), .opa_sel_i(opa_sel), .opb_sel_i(opb_sel),
        .alu_func_i(func), .cond_branch_i(cond), .uncond_branch_i(uncond),
        .tag_i(tag), .rob_idx_i(rob), .start_i(start), .ack_i(ack),
        .ready_i(ready), .valid_i(valid), .alu_result_i(alu_result),
        .mult_result_i(mult_result), .br_target_i(br_target), .br_taken_i(br_taken),
        .alu_tag_i(alu_tag), .mult_tag_i(mult_tag), .br_tag_i(br_tag),
        .alu_rob_i(alu_rob), .mult_rob_i(mult_rob), .br_rob_i(br_rob),
        .err_count_o(chk_errs), .result_count_o(results)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic random_bus();
        logic [31:0] r;
        inst = next_rand();
        r    = next_rand();
        pc   = {r[31:2], 2'b00};
        npc  = pc + 32'd4;
        rs1  = next_rand();
        rs2  = next_rand();
        r    = next_rand();
        tag  = r[5:0];
        rob  = r[12:8];
    endtask

    // Issue on unit u and ack after ack_delay held cycles
    task automatic run_op(int u, int ack_delay, logic poke);
        int n;
        n = 0;
        while (!ready[u] && n < 50 && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (timed_out) begin
            return;
        end
        if (!ready[u]) begin
            $display("unit %0d never became ready within 50 cycles", u);
            timed_out = 1'b1;
            return;
        end
        start[u] = 1'b1;
        @(posedge clk);
        #1;
        start[u] = 1'b0;
        n = 0;
        while (!valid[u] && n < 50) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!valid[u]) begin
            $display("unit %0d never raised valid within 50 cycles", u);
            timed_out = 1'b1;
            return;
        end
        for (int i = 0; i < ack_delay; i++) begin
            start[u] = poke && (i == 0); // Should be ignored while busy
            random_bus();
            @(posedge clk);
            #1;
        end
        ack[u]   = 1'b1;
        start[u] = poke;
        @(posedge clk);
        #1;
        ack[u]   = 1'b0;
        start[u] = 1'b0;
    endtask

    task automatic end_test(string name);
        int e;
        e = chk_errs + tb_errs - errs_before;
        tests_run++;
        if (e != 0) tests_failed++;
        $display("test %-14s %s (%0d errors)", name, (e == 0) ? "ok" : "FAILED", e);
        errs_before = chk_errs + tb_errs;
    endtask

    initial begin
        logic [31:0] r;
        lcg_state = 32'hd8a1_5add;
        reset = 1'b1;
        start = '0;
        ack = '0;
        inst = '0;
        pc = '0;
        npc = '0;
        rs1 = '0;
        rs2 = '0;
        opa_sel = OPA_IS_RS1;
        opb_sel = OPB_IS_RS2;
        func = ALU_ADD;
        cond = 1'b0;
        uncond = 1'b0;
        tag = '0;
        rob = '0;
        tb_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        errs_before = 0;
        timed_out = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk); // Checker looks at the reset state on this edge
        #1;
        end_test("reset");

        for (int k = 0; k < 60; k++) begin // ALU over all selects
            random_bus();
            r = next_rand();
            func = alu_func_e'(r[7:0] % 10);
            opa_sel = opa_sel_e'(r[9:8]);
            opb_sel = opb_sel_e'(r[18:16] % 6);
            run_op(0, 0, 1'b0);
        end
        end_test("alu");

        for (int k = 0; k < 24; k++) begin // Multiply
            random_bus();
            func = alu_func_e'(10 + k % 4);
            opa_sel = OPA_IS_RS1;
            opb_sel = OPB_IS_RS2;
            if (k % 3 == 0) rs2 = -rs2;
            run_op(1, 0, 1'b0);
        end
        end_test("mult");

        for (int k = 0; k < 32; k++) begin // Branch over funct3 and cond/uncond
            random_bus();
            inst[14:12] = 3'(k / 4);
            cond = k[0];
            uncond = k[1];
            if (k % 3 == 0) rs2 = rs1;
            func = ALU_ADD;
            opa_sel = OPA_IS_PC;
            opb_sel = (k % 2 == 0) ? OPB_IS_B_IMM : OPB_IS_J_IMM;
            run_op(2, 0, 1'b0);
        end
        end_test("branch");

        for (int k = 0; k < 18; k++) begin // Late acks with stray starts
            random_bus();
            r = next_rand();
            func = (k % 3 == 1) ? ALU_MULH : ALU_SUB;
            opa_sel = OPA_IS_RS1;
            opb_sel = OPB_IS_RS2;
            run_op(k % 3, 1 + int'(r[2:0]), 1'b1);
        end
        repeat (3) @(posedge clk);
        #1;
        end_test("backpressure");

        if (results != 60 + 24 + 32 + 18) begin
            $display("expected %0d results, checker counted %0d", 134, results);
            tb_errs++;
        end
        $display("tests run %0d, failed %0d, checker errors %0d, testbench errors %0d",
                 tests_run, tests_failed, chk_errs, tb_errs);
        if (chk_errs == 0 && tb_errs == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
fu_pkg.sv
operand_mux.sv
int_alu.sv
fu_sequencer.sv
alu_unit.sv
mult_unit.sv
branch_unit.sv
fu_top.sv
fu_checker.sv
fu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fu_tb -f project.f \
    -o fu_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/fu_sim > sim.log 2>&1 || { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
